// ==== dna_pkg.sv ====
//--------------------
// identifier and license key widths, typedefs
// flow step constants and key constants
//--------------------
package dna_pkg;

	//--------------------
	// widths
	//--------------------
	// factory identifier length in bits
	localparam int ID_BITS = 57;
	// license key and output bus width
	localparam int KEY_BITS = 64;
	// constant tag on top of the key
	localparam int TAG_BITS = 8;
	// identifier bits that end up in the key
	localparam int BODY_BITS = KEY_BITS - TAG_BITS;

	// captured identifier
	typedef logic [ID_BITS-1:0] id_t;
	// license key or zero-extended identifier
	typedef logic [KEY_BITS-1:0] key_t;
	// flow counter, one step per identifier clock period
	typedef logic [6:0] flow_t;

	//--------------------
	// flow steps
	//--------------------
	// read pulse loads the cell's shift register
	localparam flow_t STEP_READ = 7'd2;
	// 56 shift periods follow the read
	localparam flow_t STEP_SHIFT_FIRST = 7'd3;
	localparam flow_t STEP_SHIFT_LAST = 7'd58;
	// counter parks here for good
	localparam flow_t STEP_DONE = 7'd64;

	//--------------------
	// key constants
	//--------------------
	localparam logic [TAG_BITS-1:0] KEY_TAG = 8'h47;
	// every other bit of the identifier body survives
	localparam logic [BODY_BITS-1:0] KEY_MASK = 56'haa_aaaa_aaaa_aaaa;

endpackage

// ==== id_ctrl.sv ====
//--------------------
// identifier clock divider, flow counter
// read, shift, capture and done strobes
//--------------------
`timescale 1ns/10ps

module id_ctrl
	import dna_pkg::*;
#(
	// identifier clock period is 2**DIV_BITS system clocks
	parameter int DIV_BITS = 5
) (
	input logic clk,
	input logic reset,
	output logic id_clk,
	output logic id_read,
	output logic id_shift,
	output logic capture_en,
	output logic id_done
);

	// phase of the sequence, decoded from the flow step
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_SHIFT,
		ST_DONE
	} state_t;

	logic [DIV_BITS-1:0] div_cnt;
	// last system cycle of the id_clk high phase
	logic div_wrap;
	flow_t flow_cnt;
	flow_t flow_next;
	state_t state;
	state_t state_next;

	//--------------------
	// clock divider
	//--------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// msb of the divider is the identifier clock
	assign id_clk = div_cnt[DIV_BITS-1];
	// all ones means id_clk falls after this cycle
	assign div_wrap = &div_cnt;

	//--------------------
	// flow counter
	//--------------------
	always_comb begin
		flow_next = flow_cnt;
		// one step per id_clk period, stop at done
		if (div_wrap && (flow_cnt != STEP_DONE)) begin
			flow_next = flow_cnt + 1'b1;
		end
	end

	// state follows the step about to be entered
	// so the strobes line up with the step boundaries
	always_comb begin
		if (flow_next == STEP_DONE) begin
			state_next = ST_DONE;
		end else if (flow_next == STEP_READ) begin
			state_next = ST_LOAD;
		end else if ((flow_next >= STEP_SHIFT_FIRST) && (flow_next <= STEP_SHIFT_LAST)) begin
			state_next = ST_SHIFT;
		end else begin
			// steps 0..1 and the gap 59..63
			state_next = ST_IDLE;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			flow_cnt <= '0;
			state <= ST_IDLE;
		end else begin
			flow_cnt <= flow_next;
			state <= state_next;
		end
	end

	//--------------------
	// strobes
	//--------------------
	// read and shift are held for whole identifier periods
	// the cell samples them on the rising edge of id_clk mid-step
	assign id_read = (state == ST_LOAD);
	assign id_shift = (state == ST_SHIFT);

	// sample dout at each falling edge of steps 2..58
	// first capture is the bit loaded by read, then 56 shifted bits
	assign capture_en = div_wrap && ((state == ST_LOAD) || (state == ST_SHIFT));

	// sticky until the next reset
	assign id_done = (state == ST_DONE);

endmodule

// ==== id_shifter.sv ====
//--------------------
// serial capture register for the identifier
//--------------------
`timescale 1ns/10ps

module id_shifter
	import dna_pkg::*;
(
	input logic clk,
	input logic reset,
	// serial data from the identifier cell
	input logic id_dout,
	// one pulse per identifier bit
	input logic capture_en,
	output key_t id_value
);

	// zero bits above the identifier on the key-wide bus
	localparam int PAD_BITS = KEY_BITS - ID_BITS;

	id_t id_reg;

	//--------------------
	// shift in
	//--------------------
	// msb arrives first, so shift toward the top
	// after 57 pulses bit 56 sits at the msb
	always_ff @(posedge clk) begin
		if (reset) begin
			id_reg <= '0;
		end else if (capture_en) begin
			id_reg <= {id_reg[ID_BITS-2:0], id_dout};
		end
	end

	//--------------------
	// output
	//--------------------
	// zero-extended to the key width
	assign id_value = {{PAD_BITS{1'b0}}, id_reg};

endmodule

// ==== license_check.sv ====
//--------------------
// expected license key register
// registered key comparison
//--------------------
`timescale 1ns/10ps

module license_check
	import dna_pkg::*;
(
	input logic clk,
	input logic reset,
	// identifier capture complete
	input logic id_done,
	// zero-extended identifier
	input key_t id_value,
	// key presented from outside
	input key_t encrypt_key,
	output logic license_ok
);

	key_t exp_key;
	// expected key holds a real value
	logic key_valid;
	logic key_match;

	//--------------------
	// expected key
	//--------------------
	// tag byte on top of the masked identifier body
	// bit 56 of the identifier is dropped
	always_ff @(posedge clk) begin
		if (reset) begin
			exp_key <= '0;
			key_valid <= 1'b0;
		end else if (id_done) begin
			exp_key <= {KEY_TAG, id_value[BODY_BITS-1:0] & KEY_MASK};
			key_valid <= 1'b1;
		end else begin
			exp_key <= '0;
			key_valid <= 1'b0;
		end
	end

	//--------------------
	// comparison
	//--------------------
	// a zero key must not pass while the identifier is still coming in
	assign key_match = key_valid && (exp_key == encrypt_key);

	// valid two cycles after id_done
	// then tracks encrypt_key one cycle late
	always_ff @(posedge clk) begin
		if (reset) begin
			license_ok <= 1'b0;
		end else begin
			license_ok <= key_match;
		end
	end

endmodule

// ==== dna_license_top.sv ====
//--------------------
// identifier read and license check top level
// serial identifier pins go to the external cell
//--------------------
`timescale 1ns/10ps

module dna_license_top
	import dna_pkg::*;
#(
	// identifier clock divider width
	parameter int DIV_BITS = 5
) (
	input logic clk,
	input logic reset,
	// serial data from the identifier cell
	input logic id_dout,
	// key to check against the identifier
	input key_t encrypt_key,
	// identifier cell clock and controls
	output logic id_clk,
	output logic id_read,
	output logic id_shift,
	// capture finished
	output logic id_done,
	// registered key match
	output logic license_ok,
	// captured identifier, zero-extended
	output key_t id_value
);

	// one pulse per identifier bit
	logic capture_en;

	//--------------------
	// control
	//--------------------
	id_ctrl #(
		.DIV_BITS(DIV_BITS)
	) ctrl_i (
		.clk(clk),
		.reset(reset),
		.id_clk(id_clk),
		.id_read(id_read),
		.id_shift(id_shift),
		.capture_en(capture_en),
		.id_done(id_done)
	);

	//--------------------
	// identifier capture
	//--------------------
	id_shifter shifter_i (
		.clk(clk),
		.reset(reset),
		.id_dout(id_dout),
		.capture_en(capture_en),
		.id_value(id_value)
	);

	//--------------------
	// key check
	//--------------------
	license_check check_i (
		.clk(clk),
		.reset(reset),
		.id_done(id_done),
		.id_value(id_value),
		.encrypt_key(encrypt_key),
		.license_ok(license_ok)
	);

endmodule

// ==== dna_license_sva.sv ====
//--------------------
// bound checks on the identifier strobes
// and the done level
//--------------------
`timescale 1ns/10ps

module dna_license_sva (
	input logic clk,
	input logic reset,
	input logic id_read,
	input logic id_shift,
	input logic id_done
);

	//--------------------
	// strobe sequence
	//--------------------
	// read loads the cell, shift moves it, never both at once
	read_shift_excl: assert property (
		@(posedge clk) disable iff (reset) !(id_read && id_shift)
	) else $error("id_read and id_shift are high in the same cycle");

	// no shifting once the sequence has finished
	shift_after_done: assert property (
		@(posedge clk) disable iff (reset) !(id_shift && id_done)
	) else $error("id_shift is high while id_done is high");

	//--------------------
	// done level
	//--------------------
	// done only drops because reset was applied
	done_sticky: assert property (
		@(posedge clk) $fell(id_done) |-> $past(reset)
	) else $error("id_done fell without a reset");

endmodule

// attach to every control block in the design
bind id_ctrl dna_license_sva sva_i (
	.clk(clk),
	.reset(reset),
	.id_read(id_read),
	.id_shift(id_shift),
	.id_done(id_done)
);

// ==== tb_clock.sv ====
//--------------------
// testbench clock source
//--------------------
`timescale 1ns/10ps

module tb_clock #(
	// full clock period in ns
	parameter int PERIOD_NS = 100
) (
	output logic clk
);

	// starts low, first rising edge at half a period
	initial begin
		clk = 1'b0;
	end

	always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// ==== id_cell_model.sv ====
//--------------------
// behavioral identifier cell
// load on read, shift on strobe, msb on dout
//--------------------
`timescale 1ns/10ps

module id_cell_model #(
	// factory identifier length
	parameter int ID_LEN = 57
) (
	// slow clock from the design
	input logic id_clk,
	// parallel load of the factory value
	input logic id_read,
	// one bit toward the msb per id_clk edge
	input logic id_shift,
	// factory value burnt into the cell
	input logic [ID_LEN-1:0] dna_id,
	// serial data back to the design
	output logic id_dout
);

	// internal shift register of the cell
	logic [ID_LEN-1:0] shift_reg = '0;

	//--------------------
	// cell behavior
	//--------------------
	// both controls sampled on the rising edge of id_clk
	// read wins if both are high, same as the primitive
	always @(posedge id_clk) begin
		if (id_read) begin
			shift_reg <= dna_id;
		end else if (id_shift) begin
			// din of the primitive is tied low
			shift_reg <= {shift_reg[ID_LEN-2:0], 1'b0};
		end
	end

	// msb is always visible on dout
	assign id_dout = shift_reg[ID_LEN-1];

endmodule

// ==== tb_top.sv ====
//--------------------
// testbench top for the identifier license check
// reads cases, checks capture and key match
//--------------------
`timescale 1ns/10ps

module tb_top;

	// fast identifier clock, 4 system clocks per period
	localparam int DIV_BITS = 2;
	localparam int ID_PERIOD = 1 << DIV_BITS;
	localparam int MAX_CASES = 16;
	// id, key 1, key 2, flag 1, flag 2
	localparam int CASE_WORDS = 5;
	// a full sequence is 64 periods plus reset and checks
	localparam int TIMEOUT_PERIODS = 70;
	localparam logic [7:0] TAG_BYTE = 8'h47;
	localparam logic [55:0] BODY_MASK = {7{8'haa}};

	logic clk;
	logic reset;
	logic id_dout;
	logic [63:0] encrypt_key;
	logic id_clk;
	logic id_read;
	logic id_shift;
	logic id_done;
	logic license_ok;
	logic [63:0] id_value;
	// value the cell model hands out
	logic [56:0] model_id;

	logic [63:0] cases_mem [0:MAX_CASES*CASE_WORDS-1];
	int num_cases;
	int case_idx;
	logic cases_ready;
	// strobes the cell has seen since the last reset
	int read_count;
	int shift_count;

	//--------------------
	// instances
	//--------------------
	tb_clock #(.PERIOD_NS(100)) clock_i (.clk(clk));

	dna_license_top #(
		.DIV_BITS(DIV_BITS)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.id_dout(id_dout),
		.encrypt_key(encrypt_key),
		.id_clk(id_clk),
		.id_read(id_read),
		.id_shift(id_shift),
		.id_done(id_done),
		.license_ok(license_ok),
		.id_value(id_value)
	);

	id_cell_model cell_i (
		.id_clk(id_clk),
		.id_read(id_read),
		.id_shift(id_shift),
		.dna_id(model_id),
		.id_dout(id_dout)
	);

	//--------------------
	// strobe counters
	//--------------------
	// same sampling point as the cell, rising edge of id_clk
	always @(posedge id_clk or posedge reset) begin
		if (reset) begin
			read_count <= 0;
			shift_count <= 0;
		end else begin
			if (id_read) begin
				read_count <= read_count + 1;
			end
			if (id_shift) begin
				shift_count <= shift_count + 1;
			end
		end
	end

	//--------------------
	// helpers
	//--------------------
	// tag byte over the identifier body, odd bits only
	function automatic logic [63:0] license_key(input logic [56:0] id);
		return {TAG_BYTE, id[55:0] & BODY_MASK};
	endfunction

	task automatic check_value(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			$display("ERROR: case %0d %s: expected %h, actual %h",
				case_idx, what, expected, actual);
			$display("=== FAIL ===");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// unused slots get a value with bits above 56 set
	task automatic load_cases();
		for (int i = 0; i < MAX_CASES * CASE_WORDS; i++) begin
			cases_mem[i] = ~64'(i);
		end
		$readmemh("dna_cases.txt", cases_mem);
		num_cases = 0;
		while ((num_cases < MAX_CASES) && (cases_mem[num_cases*CASE_WORDS][63:57] == 7'd0)) begin
			num_cases++;
		end
	endtask

	//--------------------
	// one case
	//--------------------
	task automatic run_case(input int idx);
		logic [56:0] id;
		logic [63:0] key_1;
		logic [63:0] key_2;
		logic match_1;
		logic match_2;
		id = cases_mem[idx*CASE_WORDS][56:0];
		key_1 = cases_mem[idx*CASE_WORDS+1];
		key_2 = cases_mem[idx*CASE_WORDS+2];
		match_1 = (key_1 == license_key(id));
		match_2 = (key_2 == license_key(id));
		// case file flags must agree with the key rule
		check_value("case file flag for key 1", 64'(match_1), cases_mem[idx*CASE_WORDS+3]);
		check_value("case file flag for key 2", 64'(match_2), cases_mem[idx*CASE_WORDS+4]);

		// reset for 5 cycles, new identifier in the cell
		@(posedge clk);
		model_id <= id;
		reset <= 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		check_value("id_done during reset", 64'd0, 64'(id_done));
		check_value("license_ok during reset", 64'd0, 64'(license_ok));
		check_value("id_value during reset", 64'd0, id_value);
		@(posedge clk);
		reset <= 1'b0;
		// all-zero key against the still empty expected key
		encrypt_key <= '0;
		@(negedge clk);
		check_value("id_value after reset", 64'd0, id_value);

		// zero key up to the read pulse
		while (!id_read) begin
			check_value("license_ok for zero key", 64'd0, 64'(license_ok));
			@(negedge clk);
		end
		@(posedge clk);
		encrypt_key <= key_1;
		@(negedge clk);

		// no match can show before the capture is over
		while (!id_done) begin
			check_value("license_ok before id_done", 64'd0, 64'(license_ok));
			@(negedge clk);
		end

		// expected key one cycle, comparison one more
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_value("id_value after capture", {7'd0, id}, id_value);
		check_value("id_done after capture", 64'd1, 64'(id_done));
		check_value("license_ok for key 1", 64'(match_1), 64'(license_ok));
		// one read, then 56 shifts
		check_value("read strobes", 64'd1, 64'(read_count));
		check_value("shift strobes", 64'd56, 64'(shift_count));

		// second key, exactly one cycle of latency
		@(posedge clk);
		encrypt_key <= key_2;
		@(negedge clk);
		check_value("license_ok before key 2 lands", 64'(match_1), 64'(license_ok));
		@(posedge clk);
		@(negedge clk);
		check_value("license_ok for key 2", 64'(match_2), 64'(license_ok));
	endtask

	//--------------------
	// main sequence
	//--------------------
	initial begin
		reset = 1'b1;
		encrypt_key = '0;
		model_id = '0;
		case_idx = 0;
		cases_ready = 1'b0;
		load_cases();
		if (num_cases == 0) begin
			$display("no test cases could be read from dna_cases.txt");
			$display("=== FAIL ===");
			$fatal(1, "empty case file");
		end else begin
			cases_ready = 1'b1;
			for (int c = 0; c < num_cases; c++) begin
				case_idx = c;
				run_case(c);
			end
			$display("=== PASS ===");
			$finish;
		end
	end

	// watchdog, limit scales with the number of cases
	initial begin
		wait (cases_ready);
		repeat (num_cases * TIMEOUT_PERIODS * ID_PERIOD) @(posedge clk);
		$display("timeout: id_done never came, stuck in case %0d", case_idx);
		$display("=== FAIL ===");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== dna_cases.txt ====
// identifier (57 bits)  key_1  key_2  ok_1  ok_2, all hex
// ok flags are 1 where the key matches tag 47 over the masked identifier
01ffffffffffffff 47aaaaaaaaaaaaaa 47aaaaaaaaaaaaab 1 0
0000000000000000 4700000000000000 0000000000000000 1 0
00aaaaaaaaaaaaaa 47aaaaaaaaaaaaaa 46aaaaaaaaaaaaaa 1 0
0155555555555555 4800000000000000 4700000000000000 0 1
0123456789abcdef 4722002288aa88aa 4723456789abcdef 1 0
0000000000000001 4700000000000000 4700000000000001 1 0
0100000000000000 4700000000000000 c700000000000000 1 0
0080000000000000 4700000000000000 4780000000000000 0 1
00fedcba98765432 47aa88aa88220022 47aa88aa88220023 1 0
01c3a5f00f5a3c96 4782a0a00a0a2883 4782a0a00a0a2882 0 1
0077777777777777 4722222222222222 0000000000000000 1 0
0000000000000000 47aaaaaaaaaaaaaa 4700000000000000 0 1

// ==== project.f ====
dna_pkg.sv
id_ctrl.sv
id_shifter.sv
license_check.sv
dna_license_top.sv
dna_license_sva.sv
tb_clock.sv
id_cell_model.sv
tb_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

rm -rf "$BUILD_DIR"
verilator --binary --timing --assert -j 0 \
	--top-module tb_top -Mdir "$BUILD_DIR" -f project.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/Vtb_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "pass message not found in $LOG"
	exit 1
fi
